/* dual_pkg.sv */
package dual_pkg;

    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    // instruction field positions
    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 26;
    localparam int OP_W    = OP_MSB - OP_LSB + 1;
    localparam int RD_MSB  = 4;
    localparam int RD_LSB  = 0;
    localparam int RJ_MSB  = 9;
    localparam int RJ_LSB  = 5;
    localparam int RK_MSB  = 14;
    localparam int RK_LSB  = 10;
    localparam int IMM_MSB = 21;   // overlaps rk, only addi reads it
    localparam int IMM_LSB = 10;
    localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

    typedef enum logic [OP_W-1:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SLL  = 6'h06,
        OP_SRL  = 6'h07,
        OP_SLT  = 6'h08,   // signed compare
        OP_ADDI = 6'h09
    } op_e;

endpackage

/* issue_decode.sv */
module issue_decode (
    input  logic [dual_pkg::INST_W-1:0]     inst0,
    input  logic [dual_pkg::INST_W-1:0]     inst1,
    input  logic                            valid0,
    input  logic                            valid1,
    output dual_pkg::op_e                   op0,
    output dual_pkg::op_e                   op1,
    output logic [dual_pkg::REG_ADDR_W-1:0] rd0,
    output logic [dual_pkg::REG_ADDR_W-1:0] rd1,
    output logic [dual_pkg::REG_ADDR_W-1:0] rj0,
    output logic [dual_pkg::REG_ADDR_W-1:0] rj1,
    output logic [dual_pkg::REG_ADDR_W-1:0] rk0,
    output logic [dual_pkg::REG_ADDR_W-1:0] rk1,
    output logic [31:0]                     imm0,
    output logic [31:0]                     imm1,
    output logic                            wen0,
    output logic                            wen1
);

    // unknown encodings fold into nop
    function automatic dual_pkg::op_e decode_op(input logic [dual_pkg::OP_W-1:0] field);
        dual_pkg::op_e op;
        case (field)
            dual_pkg::OP_ADD:  op = dual_pkg::OP_ADD;
            dual_pkg::OP_SUB:  op = dual_pkg::OP_SUB;
            dual_pkg::OP_AND:  op = dual_pkg::OP_AND;
            dual_pkg::OP_OR:   op = dual_pkg::OP_OR;
            dual_pkg::OP_XOR:  op = dual_pkg::OP_XOR;
            dual_pkg::OP_SLL:  op = dual_pkg::OP_SLL;
            dual_pkg::OP_SRL:  op = dual_pkg::OP_SRL;
            dual_pkg::OP_SLT:  op = dual_pkg::OP_SLT;
            dual_pkg::OP_ADDI: op = dual_pkg::OP_ADDI;
            default:           op = dual_pkg::OP_NOP;
        endcase
        return op;
    endfunction

    function automatic logic [31:0] sext_imm(input logic [dual_pkg::INST_W-1:0] inst);
        return {{(32 - dual_pkg::IMM_W){inst[dual_pkg::IMM_MSB]}},
                inst[dual_pkg::IMM_MSB:dual_pkg::IMM_LSB]};
    endfunction

    assign op0 = decode_op(inst0[dual_pkg::OP_MSB:dual_pkg::OP_LSB]);
    assign op1 = decode_op(inst1[dual_pkg::OP_MSB:dual_pkg::OP_LSB]);

    assign rd0 = inst0[dual_pkg::RD_MSB:dual_pkg::RD_LSB];
    assign rd1 = inst1[dual_pkg::RD_MSB:dual_pkg::RD_LSB];
    assign rj0 = inst0[dual_pkg::RJ_MSB:dual_pkg::RJ_LSB];
    assign rj1 = inst1[dual_pkg::RJ_MSB:dual_pkg::RJ_LSB];
    assign rk0 = inst0[dual_pkg::RK_MSB:dual_pkg::RK_LSB];
    assign rk1 = inst1[dual_pkg::RK_MSB:dual_pkg::RK_LSB];

    assign imm0 = sext_imm(inst0);
    assign imm1 = sext_imm(inst1);

    // r0 writes are dropped here so nothing downstream has to check
    assign wen0 = valid0 && (op0 != dual_pkg::OP_NOP) && (rd0 != '0);
    assign wen1 = valid1 && (op1 != dual_pkg::OP_NOP) && (rd1 != '0);

endmodule

/* regfile_4r2w.sv */
module regfile_4r2w #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [dual_pkg::REG_ADDR_W-1:0] raddr00,
    input  logic [dual_pkg::REG_ADDR_W-1:0] raddr01,
    input  logic [dual_pkg::REG_ADDR_W-1:0] raddr10,
    input  logic [dual_pkg::REG_ADDR_W-1:0] raddr11,
    output logic [DATA_W-1:0]               rdata00,
    output logic [DATA_W-1:0]               rdata01,
    output logic [DATA_W-1:0]               rdata10,
    output logic [DATA_W-1:0]               rdata11,
    input  logic                            wen0,
    input  logic                            wen1,
    input  logic [dual_pkg::REG_ADDR_W-1:0] waddr0,
    input  logic [dual_pkg::REG_ADDR_W-1:0] waddr1,
    input  logic [DATA_W-1:0]               wdata0,
    input  logic [DATA_W-1:0]               wdata1
);

    localparam int NREGS = 1 << dual_pkg::REG_ADDR_W;

    logic [DATA_W-1:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0 && waddr0 != '0) regs[waddr0] <= wdata0;
            if (wen1 && waddr1 != '0) regs[waddr1] <= wdata1;   // later write, lane 1 wins
        end
    end

    // same-cycle write bypass, lane 1 first
    function automatic logic [DATA_W-1:0] read_port(input logic [dual_pkg::REG_ADDR_W-1:0] addr);
        if (addr == '0) return '0;
        if (wen1 && waddr1 == addr) return wdata1;
        if (wen0 && waddr0 == addr) return wdata0;
        return regs[addr];
    endfunction

    always_comb begin
        rdata00 = read_port(raddr00);
        rdata01 = read_port(raddr01);
        rdata10 = read_port(raddr10);
        rdata11 = read_port(raddr11);
    end

    // r0 is never a write target
    a_wen0_addr: assert property (@(posedge clk) disable iff (!rst_n) wen0 |-> waddr0 != '0);
    a_wen1_addr: assert property (@(posedge clk) disable iff (!rst_n) wen1 |-> waddr1 != '0);

endmodule

/* forward.sv */
module forward #(
    parameter int DATA_W = 32
) (
    // sources from the rf stage
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu0_rj,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu0_rk,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu1_rj,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu1_rk,
    input  logic [DATA_W-1:0]               data00,
    input  logic [DATA_W-1:0]               data01,
    input  logic [DATA_W-1:0]               data10,
    input  logic [DATA_W-1:0]               data11,
    // level 0, exe1 registers
    input  logic                            eu0_en_0,
    input  logic                            eu1_en_0,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu0_rd_0,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu1_rd_0,
    input  logic [DATA_W-1:0]               data_forward00,
    input  logic [DATA_W-1:0]               data_forward10,
    // level 1, exe2 registers
    input  logic                            eu0_en_1,
    input  logic                            eu1_en_1,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu0_rd_1,
    input  logic [dual_pkg::REG_ADDR_W-1:0] eu1_rd_1,
    input  logic [DATA_W-1:0]               data_forward01,
    input  logic [DATA_W-1:0]               data_forward11,
    output logic [DATA_W-1:0]               eu0_sr0,
    output logic [DATA_W-1:0]               eu0_sr1,
    output logic [DATA_W-1:0]               eu1_sr0,
    output logic [DATA_W-1:0]               eu1_sr1
);

    // newest producer first: lane 1 before lane 0 within a level
    function automatic logic [DATA_W-1:0] pick(input logic [dual_pkg::REG_ADDR_W-1:0] src,
                                               input logic [DATA_W-1:0]               rf_val);
        if (src == '0) return rf_val;
        if (eu1_en_0 && src == eu1_rd_0) return data_forward10;
        if (eu0_en_0 && src == eu0_rd_0) return data_forward00;
        if (eu1_en_1 && src == eu1_rd_1) return data_forward11;
        if (eu0_en_1 && src == eu0_rd_1) return data_forward01;
        return rf_val;
    endfunction

    always_comb begin
        eu0_sr0 = pick(eu0_rj, data00);
        eu0_sr1 = pick(eu0_rk, data01);
        eu1_sr0 = pick(eu1_rj, data10);
        eu1_sr1 = pick(eu1_rk, data11);
    end

endmodule

/* alu_lane.sv */
module alu_lane #(
    parameter int DATA_W = 32
) (
    input  dual_pkg::op_e     op,
    input  logic [DATA_W-1:0] src0,
    input  logic [DATA_W-1:0] src1,
    input  logic [DATA_W-1:0] imm,
    output logic [DATA_W-1:0] result
);

    localparam int SHAMT_W = $clog2(DATA_W);

    logic [SHAMT_W-1:0] shamt;
    logic               lt;

    assign shamt = src1[SHAMT_W-1:0];
    assign lt    = $signed(src0) < $signed(src1);

    always_comb begin
        case (op)
            dual_pkg::OP_ADD:  result = src0 + src1;
            dual_pkg::OP_SUB:  result = src0 - src1;
            dual_pkg::OP_AND:  result = src0 & src1;
            dual_pkg::OP_OR:   result = src0 | src1;
            dual_pkg::OP_XOR:  result = src0 ^ src1;
            dual_pkg::OP_SLL:  result = src0 << shamt;
            dual_pkg::OP_SRL:  result = src0 >> shamt;   // logical
            dual_pkg::OP_SLT:  result = {{(DATA_W-1){1'b0}}, lt};
            dual_pkg::OP_ADDI: result = src0 + imm;
            default:           result = '0;              // nop
        endcase
    end

endmodule

/* exe_pipe.sv */
module exe_pipe #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  dual_pkg::op_e                   op0,
    input  dual_pkg::op_e                   op1,
    input  logic [dual_pkg::REG_ADDR_W-1:0] rd0,
    input  logic [dual_pkg::REG_ADDR_W-1:0] rd1,
    input  logic [dual_pkg::REG_ADDR_W-1:0] rj0,
    input  logic [dual_pkg::REG_ADDR_W-1:0] rj1,
    input  logic [dual_pkg::REG_ADDR_W-1:0] rk0,
    input  logic [dual_pkg::REG_ADDR_W-1:0] rk1,
    input  logic [DATA_W-1:0]               imm0,
    input  logic [DATA_W-1:0]               imm1,
    input  logic                            wen0,
    input  logic                            wen1,
    input  logic [DATA_W-1:0]               rdata00,
    input  logic [DATA_W-1:0]               rdata01,
    input  logic [DATA_W-1:0]               rdata10,
    input  logic [DATA_W-1:0]               rdata11,
    output logic                            wb_en0,
    output logic                            wb_en1,
    output logic [dual_pkg::REG_ADDR_W-1:0] wb_rd0,
    output logic [dual_pkg::REG_ADDR_W-1:0] wb_rd1,
    output logic [DATA_W-1:0]               wb_data0,
    output logic [DATA_W-1:0]               wb_data1
);

    // rf stage
    logic                            rf_en0, rf_en1;
    dual_pkg::op_e                   rf_op0, rf_op1;
    logic [dual_pkg::REG_ADDR_W-1:0] rf_rd0, rf_rd1;
    logic [dual_pkg::REG_ADDR_W-1:0] rf_rj0, rf_rj1, rf_rk0, rf_rk1;
    logic [DATA_W-1:0]               rf_imm0, rf_imm1;
    logic [DATA_W-1:0]               rf_data00, rf_data01, rf_data10, rf_data11;

    // exe1 and exe2 stages
    logic                            ex1_en0, ex1_en1, ex2_en0, ex2_en1;
    logic [dual_pkg::REG_ADDR_W-1:0] ex1_rd0, ex1_rd1, ex2_rd0, ex2_rd1;
    logic [DATA_W-1:0]               ex1_data0, ex1_data1, ex2_data0, ex2_data1;

    logic [DATA_W-1:0] src00, src01, src10, src11;
    logic [DATA_W-1:0] res0, res1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf_en0  <= 1'b0;
            rf_en1  <= 1'b0;
            ex1_en0 <= 1'b0;
            ex1_en1 <= 1'b0;
            ex2_en0 <= 1'b0;
            ex2_en1 <= 1'b0;
        end else begin
            rf_en0  <= wen0;
            rf_en1  <= wen1;
            ex1_en0 <= rf_en0;
            ex1_en1 <= rf_en1;
            ex2_en0 <= ex1_en0;
            ex2_en1 <= ex1_en1;
        end
    end

    always_ff @(posedge clk) begin
        rf_op0    <= op0;
        rf_op1    <= op1;
        rf_rd0    <= rd0;
        rf_rd1    <= rd1;
        rf_rj0    <= rj0;
        rf_rj1    <= rj1;
        rf_rk0    <= rk0;
        rf_rk1    <= rk1;
        rf_imm0   <= imm0;
        rf_imm1   <= imm1;
        rf_data00 <= rdata00;
        rf_data01 <= rdata01;
        rf_data10 <= rdata10;
        rf_data11 <= rdata11;
        ex1_rd0   <= rf_rd0;
        ex1_rd1   <= rf_rd1;
        ex1_data0 <= res0;
        ex1_data1 <= res1;
        ex2_rd0   <= ex1_rd0;
        ex2_rd1   <= ex1_rd1;
        ex2_data0 <= ex1_data0;
        ex2_data1 <= ex1_data1;
    end

    forward #(.DATA_W(DATA_W)) u_forward (
        .eu0_rj         (rf_rj0),
        .eu0_rk         (rf_rk0),
        .eu1_rj         (rf_rj1),
        .eu1_rk         (rf_rk1),
        .data00         (rf_data00),
        .data01         (rf_data01),
        .data10         (rf_data10),
        .data11         (rf_data11),
        .eu0_en_0       (ex1_en0),
        .eu1_en_0       (ex1_en1),
        .eu0_rd_0       (ex1_rd0),
        .eu1_rd_0       (ex1_rd1),
        .data_forward00 (ex1_data0),
        .data_forward10 (ex1_data1),
        .eu0_en_1       (ex2_en0),
        .eu1_en_1       (ex2_en1),
        .eu0_rd_1       (ex2_rd0),
        .eu1_rd_1       (ex2_rd1),
        .data_forward01 (ex2_data0),
        .data_forward11 (ex2_data1),
        .eu0_sr0        (src00),
        .eu0_sr1        (src01),
        .eu1_sr0        (src10),
        .eu1_sr1        (src11)
    );

    alu_lane #(.DATA_W(DATA_W)) alu0 (
        .op     (rf_op0),
        .src0   (src00),
        .src1   (src01),
        .imm    (rf_imm0),
        .result (res0)
    );

    alu_lane #(.DATA_W(DATA_W)) alu1 (
        .op     (rf_op1),
        .src0   (src10),
        .src1   (src11),
        .imm    (rf_imm1),
        .result (res1)
    );

    assign wb_en0   = ex2_en0;
    assign wb_en1   = ex2_en1;
    assign wb_rd0   = ex2_rd0;
    assign wb_rd1   = ex2_rd1;
    assign wb_data0 = ex2_data0;
    assign wb_data1 = ex2_data1;

    // rd rides alongside the enable from decode through every stage
    a_ex2_rd0: assert property (@(posedge clk) disable iff (!rst_n) ex2_en0 |-> ex2_rd0 != '0);
    a_ex2_rd1: assert property (@(posedge clk) disable iff (!rst_n) ex2_en1 |-> ex2_rd1 != '0);

endmodule

/* dual_issue_core.sv */
module dual_issue_core #(
    parameter int DATA_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [dual_pkg::INST_W-1:0]     inst0,
    input  logic [dual_pkg::INST_W-1:0]     inst1,
    input  logic                            valid0,
    input  logic                            valid1,
    output logic                            retire_en0,
    output logic                            retire_en1,
    output logic [dual_pkg::REG_ADDR_W-1:0] retire_rd0,
    output logic [dual_pkg::REG_ADDR_W-1:0] retire_rd1,
    output logic [DATA_W-1:0]               retire_data0,
    output logic [DATA_W-1:0]               retire_data1
);

    dual_pkg::op_e                   op0, op1;
    logic [dual_pkg::REG_ADDR_W-1:0] rd0, rd1, rj0, rj1, rk0, rk1;
    logic [DATA_W-1:0]               imm0, imm1;
    logic                            wen0, wen1;
    logic [DATA_W-1:0]               rdata00, rdata01, rdata10, rdata11;

    issue_decode u_decode (
        .inst0  (inst0),
        .inst1  (inst1),
        .valid0 (valid0),
        .valid1 (valid1),
        .op0    (op0),
        .op1    (op1),
        .rd0    (rd0),
        .rd1    (rd1),
        .rj0    (rj0),
        .rj1    (rj1),
        .rk0    (rk0),
        .rk1    (rk1),
        .imm0   (imm0),
        .imm1   (imm1),
        .wen0   (wen0),
        .wen1   (wen1)
    );

    // write ports come from exe2, same as retire
    regfile_4r2w #(.DATA_W(DATA_W)) u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr00 (rj0),
        .raddr01 (rk0),
        .raddr10 (rj1),
        .raddr11 (rk1),
        .rdata00 (rdata00),
        .rdata01 (rdata01),
        .rdata10 (rdata10),
        .rdata11 (rdata11),
        .wen0    (retire_en0),
        .wen1    (retire_en1),
        .waddr0  (retire_rd0),
        .waddr1  (retire_rd1),
        .wdata0  (retire_data0),
        .wdata1  (retire_data1)
    );

    exe_pipe #(.DATA_W(DATA_W)) u_exe (
        .clk      (clk),
        .rst_n    (rst_n),
        .op0      (op0),
        .op1      (op1),
        .rd0      (rd0),
        .rd1      (rd1),
        .rj0      (rj0),
        .rj1      (rj1),
        .rk0      (rk0),
        .rk1      (rk1),
        .imm0     (imm0),
        .imm1     (imm1),
        .wen0     (wen0),
        .wen1     (wen1),
        .rdata00  (rdata00),
        .rdata01  (rdata01),
        .rdata10  (rdata10),
        .rdata11  (rdata11),
        .wb_en0   (retire_en0),
        .wb_en1   (retire_en1),
        .wb_rd0   (retire_rd0),
        .wb_rd1   (retire_rd1),
        .wb_data0 (retire_data0),
        .wb_data1 (retire_data1)
    );

endmodule

/* tb_dual_issue.sv */
module tb_dual_issue;

    localparam int DATA_W = 32;
    // reset, r0 reads, opcodes, dependencies, priority, random fill + stream + drain
    localparam int TEST_CYCLES = 16 + 8 + 56 + 29 + 21 + 220;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic              clk, rst_n;
    logic [31:0]       inst0, inst1;
    logic              valid0, valid1;
    logic              retire_en0, retire_en1;
    logic [4:0]        retire_rd0, retire_rd1;
    logic [DATA_W-1:0] retire_data0, retire_data1;

    logic [31:0] model [32];   // reference registers in program order
    logic [37:0] exp0 [3];     // {en, rd, data}, [2] retires now
    logic [37:0] exp1 [3];
    logic [15:0] lfsr;
    int          cycles = 0;

    dual_issue_core #(.DATA_W(DATA_W)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $fatal(1, "stopped at the cycle limit");
        end
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rr_inst(input dual_pkg::op_e op,
                                            input logic [4:0] rd, rj, rk);
        return {op, 11'b0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, rj, input logic [11:0] imm);
        return {dual_pkg::OP_ADDI, 4'b0, imm, rj, rd};
    endfunction

    // expected {en, rd, data} of one lane against the model before the bundle
    function automatic logic [37:0] model_lane(input logic [31:0] inst, input logic valid);
        logic [4:0]  rd;
        logic [31:0] a, b, imm, res;
        logic        known;
        rd    = inst[4:0];
        a     = model[inst[9:5]];
        b     = model[inst[14:10]];
        imm   = {{20{inst[21]}}, inst[21:10]};
        known = 1'b1;
        case (inst[31:26])
            dual_pkg::OP_ADD:  res = a + b;
            dual_pkg::OP_SUB:  res = a - b;
            dual_pkg::OP_AND:  res = a & b;
            dual_pkg::OP_OR:   res = a | b;
            dual_pkg::OP_XOR:  res = a ^ b;
            dual_pkg::OP_SLL:  res = a << b[4:0];
            dual_pkg::OP_SRL:  res = a >> b[4:0];
            dual_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            dual_pkg::OP_ADDI: res = a + imm;
            default: begin
                res   = '0;
                known = 1'b0;   // nop and unused encodings
            end
        endcase
        if (!valid || !known || rd == '0) return '0;
        return {1'b1, rd, res};
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
        if (got !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_retire();
        check_eq(32'(retire_en0), 32'(exp0[2][37]), "retire_en0");
        check_eq(32'(retire_en1), 32'(exp1[2][37]), "retire_en1");
        if (exp0[2][37]) begin
            check_eq(32'(retire_rd0), 32'(exp0[2][36:32]), "retire_rd0");
            check_eq(retire_data0, exp0[2][31:0], "retire_data0");
        end
        if (exp1[2][37]) begin
            check_eq(32'(retire_rd1), 32'(exp1[2][36:32]), "retire_rd1");
            check_eq(retire_data1, exp1[2][31:0], "retire_data1");
        end
    endtask

    // one cycle: check what retires now, then drive the next bundle
    task automatic issue(input logic [31:0] i0, input logic [31:0] i1,
                         input logic v0, input logic v1);
        logic [37:0] e0, e1;
        @(negedge clk);
        check_retire();
        e0 = model_lane(i0, v0);
        e1 = model_lane(i1, v1);
        if (e0[37]) model[e0[36:32]] = e0[31:0];
        if (e1[37]) model[e1[36:32]] = e1[31:0];   // lane 1 wins a shared rd
        exp0[2] = exp0[1];
        exp0[1] = exp0[0];
        exp0[0] = e0;
        exp1[2] = exp1[1];
        exp1[1] = exp1[0];
        exp1[0] = e1;
        inst0   = i0;
        inst1   = i1;
        valid0  = v0;
        valid1  = v1;
    endtask

    task automatic idle(input int n);
        repeat (n) issue('0, '0, 1'b0, 1'b0);
    endtask

    task automatic each_opcode();
        dual_pkg::op_e op;
        issue(addi_inst(5'd1, 5'd0, 12'(rand_bits(12))),
              addi_inst(5'd3, 5'd0, 12'(rand_bits(12))), 1'b1, 1'b1);
        issue(addi_inst(5'd2, 5'd0, 12'(rand_bits(12))),
              addi_inst(5'd4, 5'd0, 12'(rand_bits(12))), 1'b1, 1'b1);
        idle(4);
        for (int k = 1; k <= 8; k++) begin
            op = dual_pkg::op_e'(6'(k));
            issue(rr_inst(op, 5'd10, 5'd1, 5'd2), rr_inst(op, 5'd11, 5'd3, 5'd4), 1'b1, 1'b1);
            idle(4);
        end
        issue(addi_inst(5'd12, 5'd1, 12'h7ff), addi_inst(5'd13, 5'd3, 12'h800), 1'b1, 1'b1);
        idle(4);
        // unused encoding and a plain nop, neither retires
        issue({6'h3f, 21'h0, 5'd12}, rr_inst(dual_pkg::OP_NOP, 5'd13, 5'd1, 5'd2), 1'b1, 1'b1);
        idle(4);
    endtask

    task automatic dependency_distances();
        for (int d = 1; d <= 3; d++) begin
            issue(addi_inst(5'd7, 5'd0, 12'(rand_bits(12))),
                  addi_inst(5'd8, 5'd0, 12'(rand_bits(12))), 1'b1, 1'b1);
            idle(d - 1);
            // each lane reads one value from its own lane and one from the other
            issue(rr_inst(dual_pkg::OP_ADD, 5'd9, 5'd7, 5'd8),
                  rr_inst(dual_pkg::OP_SUB, 5'd14, 5'd8, 5'd7), 1'b1, 1'b1);
            idle(4);
        end
        repeat (4) begin
            issue(addi_inst(5'd7, 5'd7, 12'd1), addi_inst(5'd8, 5'd8, 12'hfff), 1'b1, 1'b1);
        end
        idle(4);
    endtask

    task automatic priority_cases();
        // shared rd read back through level 0, level 1 and the write bypass
        issue(addi_inst(5'd15, 5'd0, 12'h123), addi_inst(5'd15, 5'd0, 12'h456), 1'b1, 1'b1);
        repeat (3) issue(rr_inst(dual_pkg::OP_OR, 5'd16, 5'd15, 5'd0), '0, 1'b1, 1'b0);
        idle(4);
        // older producer at level 1, newer one at level 0
        issue(addi_inst(5'd17, 5'd0, 12'h0aa), '0, 1'b1, 1'b0);
        issue('0, addi_inst(5'd17, 5'd0, 12'h055), 1'b0, 1'b1);
        issue(rr_inst(dual_pkg::OP_ADD, 5'd18, 5'd17, 5'd17), '0, 1'b1, 1'b0);
        idle(4);
        issue(addi_inst(5'd0, 5'd0, 12'h321), addi_inst(5'd0, 5'd0, 12'h111), 1'b1, 1'b1);
        issue(rr_inst(dual_pkg::OP_OR, 5'd19, 5'd0, 5'd0),
              rr_inst(dual_pkg::OP_ADD, 5'd20, 5'd0, 5'd0), 1'b1, 1'b1);
        idle(4);
    endtask

    task automatic random_stream(input int n);
        dual_pkg::op_e op [2];
        logic [4:0]    rd [2], rj [2], rk [2];
        logic [11:0]   imm [2];
        logic [31:0]   word [2];
        logic          v [2];
        // fill every register, r32 wraps to r0 and is dropped
        for (int r = 1; r < 32; r += 2) begin
            issue(addi_inst(5'(r), 5'd0, 12'(rand_bits(12))),
                  addi_inst(5'(r + 1), 5'd0, 12'(rand_bits(12))), 1'b1, 1'b1);
        end
        for (int b = 0; b < n; b++) begin
            for (int l = 0; l < 2; l++) begin
                op[l]  = dual_pkg::op_e'(6'(rand_bits(4) % 10));
                rd[l]  = 5'(rand_bits(5));
                rj[l]  = 5'(rand_bits(5));
                rk[l]  = 5'(rand_bits(5));
                imm[l] = 12'(rand_bits(12));
                v[l]   = rand_bits(2) != '0;   // mostly valid
            end
            // lane 1 never reads lane 0's destination
            if (rj[1] == rd[0]) rj[1] = '0;
            if (rk[1] == rd[0]) rk[1] = '0;
            for (int l = 0; l < 2; l++) begin
                word[l] = (op[l] == dual_pkg::OP_ADDI) ? addi_inst(rd[l], rj[l], imm[l])
                                                       : rr_inst(op[l], rd[l], rj[l], rk[l]);
            end
            issue(word[0], word[1], v[0], v[1]);
        end
        idle(4);
    endtask

    initial begin
        rst_n  = 1'b0;
        inst0  = '0;
        inst1  = '0;
        valid0 = 1'b0;
        valid1 = 1'b0;
        lfsr   = 16'd56358;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            exp0[i] = '0;
            exp1[i] = '0;
        end
        idle(16);   // retire enables checked low all through reset
        rst_n = 1'b1;
        idle(4);
        issue(rr_inst(dual_pkg::OP_OR, 5'd5, 5'd0, 5'd0),
              rr_inst(dual_pkg::OP_OR, 5'd6, 5'd0, 5'd0), 1'b1, 1'b1);
        idle(3);
        each_opcode();
        dependency_distances();
        priority_cases();
        random_stream(200);
        $display("test passed");
        $finish;
    end

endmodule

/* flist.f */
dual_pkg.sv
issue_decode.sv
regfile_4r2w.sv
forward.sv
alu_lane.sv
exe_pipe.sv
dual_issue_core.sv
tb_dual_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_dual_issue
FLIST     := flist.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := test passed
SOURCES   := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
